/* verilog/blend_pkg.sv */
package blend_pkg;

        ////////////////////////////////////////////////////////////
        // pixel types
        ////////////////////////////////////////////////////////////

        // one colour or alpha channel
        typedef logic [7:0] chan_t;

        // argb with alpha in the top byte
        typedef struct packed {
                chan_t a;
                chan_t r;
                chan_t g;
                chan_t b;
        } pixel_t;

        ////////////////////////////////////////////////////////////
        // register port
        ////////////////////////////////////////////////////////////

        localparam int REG_ADDR_W = 3;
        localparam int REG_DATA_W = 32;

        localparam logic [REG_ADDR_W-1:0] REG_CONTROL = 3'd0;
        localparam logic [REG_ADDR_W-1:0] REG_BLEND   = 3'd1;
        localparam logic [REG_ADDR_W-1:0] REG_FORMAT  = 3'd2;
        localparam logic [REG_ADDR_W-1:0] REG_COUNT   = 3'd3;
        localparam logic [REG_ADDR_W-1:0] REG_STATE   = 3'd4;

        // pixels per run
        localparam int COUNT_W = 16;

        // fifo sizing
        localparam int FIFO_PTR_W = 4;
        localparam int FIFO_DEPTH = 1 << FIFO_PTR_W;

        // blender depth and result fifo headroom
        localparam int BLEND_STAGES = 2;

endpackage

/* verilog/pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo #(
        parameter int DEPTH              = blend_pkg::FIFO_DEPTH,
        parameter int ALMOST_FULL_MARGIN = blend_pkg::BLEND_STAGES
) (
        input  logic             i_wire_clock,
        input  logic             i_arst_n,
        input  logic             i_write,
        input  blend_pkg::pixel_t i_data,
        input  logic             i_read,
        output blend_pkg::pixel_t o_data,
        output logic             o_full,
        output logic             o_almost_full,
        output logic             o_empty
);
        import blend_pkg::*;

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
        localparam logic [CNT_W-1:0] FULL_LVL  = CNT_W'(DEPTH);
        localparam logic [CNT_W-1:0] AF_LVL    = CNT_W'(DEPTH - ALMOST_FULL_MARGIN);

        pixel_t           mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             do_write;
        logic             do_read;

        // full and empty guard the strobes
        assign do_write = i_write && !o_full;
        assign do_read  = i_read && !o_empty;

        always_ff @(posedge i_wire_clock) begin
                if (do_write) begin
                        mem[wr_ptr] <= i_data;
                end
        end

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_write) begin
                                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_read) begin
                                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
                        end
                        if (do_write && !do_read) begin
                                count <= count + 1'b1;
                        end else if (do_read && !do_write) begin
                                count <= count - 1'b1;
                        end
                end
        end

        // head word is always on the output
        assign o_data        = mem[rd_ptr];
        assign o_empty       = (count == '0);
        assign o_full        = (count == FULL_LVL);
        assign o_almost_full = (count >= AF_LVL);

endmodule

/* verilog/reg_decode.sv */
`timescale 1ns/10ps

module reg_decode (
        input  logic                           i_wire_clock,
        input  logic                           i_arst_n,
        input  logic                           i_reg_write,
        input  logic [blend_pkg::REG_ADDR_W-1:0] i_reg_addr,
        input  logic [blend_pkg::REG_DATA_W-1:0] i_reg_wdata,
        input  logic                           i_pair_take,
        input  logic                           i_pipe_empty,
        output logic [blend_pkg::REG_DATA_W-1:0] o_reg_rdata,
        output logic                           o_run_en,
        output blend_pkg::chan_t               o_blend_alpha,
        output logic                           o_argb_mode
);
        import blend_pkg::*;

        logic               start;
        logic               finish;
        logic [COUNT_W-1:0] count_reg;
        logic [COUNT_W-1:0] remaining;
        logic               run_active;
        logic               done;

        assign start  = i_reg_write && (i_reg_addr == REG_CONTROL) && i_reg_wdata[0];
        // last pair counted and nothing left in the blender
        assign finish = run_active && (remaining == '0) && i_pipe_empty;

        ////////////////////////////////////////////////////////////
        // configuration registers
        ////////////////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_blend_alpha <= '0;
                        o_argb_mode   <= 1'b0;
                        count_reg     <= '0;
                end else if (i_reg_write) begin
                        case (i_reg_addr)
                                REG_BLEND:  o_blend_alpha <= i_reg_wdata[7:0];
                                REG_FORMAT: o_argb_mode <= i_reg_wdata[0];
                                REG_COUNT:  count_reg <= i_reg_wdata[COUNT_W-1:0];
                                default:    ;
                        endcase
                end
        end

        ////////////////////////////////////////////////////////////
        // run state
        ////////////////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        remaining  <= '0;
                        run_active <= 1'b0;
                        done       <= 1'b0;
                end else if (start) begin
                        // a start mid-run simply reloads
                        remaining  <= count_reg;
                        run_active <= 1'b1;
                        done       <= 1'b0;
                end else begin
                        if (i_pair_take && (remaining != '0)) begin
                                remaining <= remaining - 1'b1;
                        end
                        if (finish) begin
                                run_active <= 1'b0;
                                done       <= 1'b1;
                        end
                end
        end

        assign o_run_en = (remaining != '0);

        // control reads back as zero
        always_comb begin
                o_reg_rdata = '0;
                case (i_reg_addr)
                        REG_BLEND:  o_reg_rdata[7:0] = o_blend_alpha;
                        REG_FORMAT: o_reg_rdata[0] = o_argb_mode;
                        REG_COUNT:  o_reg_rdata[COUNT_W-1:0] = count_reg;
                        REG_STATE: begin
                                o_reg_rdata[0] = run_active;
                                o_reg_rdata[1] = done;
                                o_reg_rdata[REG_DATA_W-1 -: COUNT_W] = remaining;
                        end
                        default:    o_reg_rdata = '0;
                endcase
        end

endmodule

/* verilog/alpha_blender.sv */
`timescale 1ns/10ps

module alpha_blender (
        input  logic              i_wire_clock,
        input  logic              i_arst_n,
        input  logic              i_run_en,
        input  blend_pkg::chan_t  i_blend_alpha,
        input  logic              i_argb_mode,
        input  blend_pkg::pixel_t i_src_pixel,
        input  logic              i_src_empty,
        input  blend_pkg::pixel_t i_dst_pixel,
        input  logic              i_dst_empty,
        input  logic              i_out_almost_full,
        output logic              o_src_read,
        output logic              o_dst_read,
        output logic              o_pair_take,
        output blend_pkg::pixel_t o_out_pixel,
        output logic              o_out_write,
        output logic              o_pipe_empty
);
        import blend_pkg::*;

        logic             take;
        chan_t            alpha_sel;
        logic [8:0]       alpha_inv;
        logic [2:0][7:0]  src_rgb;
        logic [2:0][7:0]  dst_rgb;
        logic [2:0][16:0] src_prod;
        logic [2:0][16:0] dst_prod;
        logic [2:0][16:0] sum;

        // stage one
        logic             s1_valid;
        logic [2:0][16:0] s1_src_prod;
        logic [2:0][16:0] s1_dst_prod;
        chan_t            s1_dst_alpha;

        // stage two
        logic             s2_valid;
        pixel_t           s2_pixel;

        // almost full leaves room for what is in flight
        assign take        = i_run_en && !i_src_empty && !i_dst_empty && !i_out_almost_full;
        assign o_src_read  = take;
        assign o_dst_read  = take;
        assign o_pair_take = take;

        ////////////////////////////////////////////////////////////
        // stage one channel products
        ////////////////////////////////////////////////////////////

        assign alpha_sel = i_argb_mode ? i_src_pixel.a : i_blend_alpha;
        assign alpha_inv = 9'd256 - {1'b0, alpha_sel};
        assign src_rgb   = {i_src_pixel.r, i_src_pixel.g, i_src_pixel.b};
        assign dst_rgb   = {i_dst_pixel.r, i_dst_pixel.g, i_dst_pixel.b};

        always_comb begin
                for (int i = 0; i < 3; i++) begin
                        src_prod[i] = 17'(src_rgb[i]) * 17'(alpha_sel);
                        dst_prod[i] = 17'(dst_rgb[i]) * 17'(alpha_inv);
                end
        end

        always_ff @(posedge i_wire_clock) begin
                s1_src_prod  <= src_prod;
                s1_dst_prod  <= dst_prod;
                s1_dst_alpha <= i_dst_pixel.a;
        end

        ////////////////////////////////////////////////////////////
        // stage two sum and pack
        ////////////////////////////////////////////////////////////

        // sum tops out at 255*256 so bit 16 stays clear
        always_comb begin
                for (int i = 0; i < 3; i++) begin
                        sum[i] = s1_src_prod[i] + s1_dst_prod[i];
                end
        end

        always_ff @(posedge i_wire_clock) begin
                s2_pixel.a <= s1_dst_alpha;
                s2_pixel.r <= sum[2][15:8];
                s2_pixel.g <= sum[1][15:8];
                s2_pixel.b <= sum[0][15:8];
        end

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        s1_valid <= 1'b0;
                        s2_valid <= 1'b0;
                end else begin
                        s1_valid <= take;
                        s2_valid <= s1_valid;
                end
        end

        assign o_out_pixel  = s2_pixel;
        assign o_out_write  = s2_valid;
        assign o_pipe_empty = !s1_valid && !s2_valid;

endmodule

/* verilog/blend_render_top.sv */
`timescale 1ns/10ps

module blend_render_top (
        input  logic                           i_wire_clock,
        input  logic                           i_arst_n,
        input  logic                           i_reg_write,
        input  logic [blend_pkg::REG_ADDR_W-1:0] i_reg_addr,
        input  logic [blend_pkg::REG_DATA_W-1:0] i_reg_wdata,
        output logic [blend_pkg::REG_DATA_W-1:0] o_reg_rdata,
        input  logic                           i_src_write,
        input  blend_pkg::pixel_t              i_src_pixel,
        output logic                           o_src_full,
        input  logic                           i_dst_write,
        input  blend_pkg::pixel_t              i_dst_pixel,
        output logic                           o_dst_full,
        input  logic                           i_out_read,
        output blend_pkg::pixel_t              o_out_pixel,
        output logic                           o_out_empty
);
        import blend_pkg::*;

        // decode to blender
        logic   run_en;
        logic   pair_take;
        logic   pipe_empty;
        chan_t  blend_alpha;
        logic   argb_mode;

        // input fifo heads
        pixel_t src_head;
        pixel_t dst_head;
        logic   src_empty;
        logic   dst_empty;
        logic   src_read;
        logic   dst_read;

        // blender to result fifo
        pixel_t blend_pixel;
        logic   blend_write;
        logic   out_almost_full;

        reg_decode decode (
                .i_wire_clock  (i_wire_clock),
                .i_arst_n      (i_arst_n),
                .i_reg_write   (i_reg_write),
                .i_reg_addr    (i_reg_addr),
                .i_reg_wdata   (i_reg_wdata),
                .i_pair_take   (pair_take),
                .i_pipe_empty  (pipe_empty),
                .o_reg_rdata   (o_reg_rdata),
                .o_run_en      (run_en),
                .o_blend_alpha (blend_alpha),
                .o_argb_mode   (argb_mode)
        );

        ////////////////////////////////////////////////////////////
        // source and destination fifos
        ////////////////////////////////////////////////////////////

        pixel_fifo src_fifo (
                .i_wire_clock  (i_wire_clock),
                .i_arst_n      (i_arst_n),
                .i_write       (i_src_write),
                .i_data        (i_src_pixel),
                .i_read        (src_read),
                .o_data        (src_head),
                .o_full        (o_src_full),
                .o_almost_full (),
                .o_empty       (src_empty)
        );

        pixel_fifo dst_fifo (
                .i_wire_clock  (i_wire_clock),
                .i_arst_n      (i_arst_n),
                .i_write       (i_dst_write),
                .i_data        (i_dst_pixel),
                .i_read        (dst_read),
                .o_data        (dst_head),
                .o_full        (o_dst_full),
                .o_almost_full (),
                .o_empty       (dst_empty)
        );

        alpha_blender blender (
                .i_wire_clock      (i_wire_clock),
                .i_arst_n          (i_arst_n),
                .i_run_en          (run_en),
                .i_blend_alpha     (blend_alpha),
                .i_argb_mode       (argb_mode),
                .i_src_pixel       (src_head),
                .i_src_empty       (src_empty),
                .i_dst_pixel       (dst_head),
                .i_dst_empty       (dst_empty),
                .i_out_almost_full (out_almost_full),
                .o_src_read        (src_read),
                .o_dst_read        (dst_read),
                .o_pair_take       (pair_take),
                .o_out_pixel       (blend_pixel),
                .o_out_write       (blend_write),
                .o_pipe_empty      (pipe_empty)
        );

        // almost full throttles the blender so no write meets a full fifo
        pixel_fifo result_fifo (
                .i_wire_clock  (i_wire_clock),
                .i_arst_n      (i_arst_n),
                .i_write       (blend_write),
                .i_data        (blend_pixel),
                .i_read        (i_out_read),
                .o_data        (o_out_pixel),
                .o_full        (),
                .o_almost_full (out_almost_full),
                .o_empty       (o_out_empty)
        );

endmodule

/* sim/blend_render_tb.sv */
`timescale 1ns/10ps

module blend_render_tb;
        import blend_pkg::*;

        localparam int WAIT_LIMIT = 300;
        localparam int MAX_PIX    = 32;

        logic                  wire_clock;
        logic                  arst_n;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] reg_addr;
        logic [REG_DATA_W-1:0] reg_wdata;
        logic [REG_DATA_W-1:0] reg_rdata;
        logic                  src_write;
        pixel_t                src_pixel;
        logic                  src_full;
        logic                  dst_write;
        pixel_t                dst_pixel;
        logic                  dst_full;
        logic                  out_read;
        pixel_t                out_pixel;
        logic                  out_empty;

        // current record from the stimulus file
        string                 test_name;
        int                    rec_mode;
        logic [7:0]            rec_blend;
        int                    rec_count;
        logic [31:0]           rec_src [MAX_PIX];
        logic [31:0]           rec_dst [MAX_PIX];
        logic [31:0]           rec_exp [MAX_PIX];

        int                    errors;
        int                    checks;
        logic                  aborted;
        integer                seed;

        blend_render_top uut (
                .i_wire_clock (wire_clock),
                .i_arst_n     (arst_n),
                .i_reg_write  (reg_write),
                .i_reg_addr   (reg_addr),
                .i_reg_wdata  (reg_wdata),
                .o_reg_rdata  (reg_rdata),
                .i_src_write  (src_write),
                .i_src_pixel  (src_pixel),
                .o_src_full   (src_full),
                .i_dst_write  (dst_write),
                .i_dst_pixel  (dst_pixel),
                .o_dst_full   (dst_full),
                .i_out_read   (out_read),
                .o_out_pixel  (out_pixel),
                .o_out_empty  (out_empty)
        );

        initial begin
                wire_clock = 1'b0;
                forever #50 wire_clock = ~wire_clock;
        end

        ////////////////////////////////////////////////////////////
        // bus level helpers
        ////////////////////////////////////////////////////////////

        // inputs change 10 ns after the edge when outputs have settled
        task automatic next_slot();
                @(posedge wire_clock);
                #10;
        endtask

        task automatic check_word(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("error %s: %s expected %h, actual %h",
                                 test_name, what, expected, actual);
                end
        endtask

        task automatic give_up(input string what);
                errors++;
                aborted = 1'b1;
                $display("timeout in %s: gave up waiting for %s", test_name, what);
        endtask

        task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
                next_slot();
                reg_write = 1'b1;
                reg_addr  = addr;
                reg_wdata = data;
                next_slot();
                reg_write = 1'b0;
        endtask

        task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
                next_slot();
                reg_addr = addr;
                #1;
                data = reg_rdata;
        endtask

        ////////////////////////////////////////////////////////////
        // pixel traffic
        ////////////////////////////////////////////////////////////

        task automatic push_pairs(input int first, input int n);
                int k;
                int idle;
                k    = first;
                idle = 0;
                while (k < first + n && !aborted) begin
                        next_slot();
                        src_write = 1'b0;
                        dst_write = 1'b0;
                        if (!src_full && !dst_full) begin
                                src_write = 1'b1;
                                dst_write = 1'b1;
                                src_pixel = rec_src[k];
                                dst_pixel = rec_dst[k];
                                k++;
                                idle = 0;
                        end else begin
                                idle++;
                                if (idle > WAIT_LIMIT) begin
                                        give_up("room in the input fifos");
                                end
                        end
                end
                next_slot();
                src_write = 1'b0;
                dst_write = 1'b0;
        endtask

        // gaps drop random cycles to let the result fifo back up
        task automatic collect_results(input int first, input int n, input logic gaps);
                int   k;
                int   idle;
                logic skip;
                k    = first;
                idle = 0;
                while (k < first + n && !aborted) begin
                        next_slot();
                        out_read = 1'b0;
                        skip     = gaps && (($random(seed) & 1) != 0);
                        if (!out_empty && !skip) begin
                                check_word($sformatf("result %0d", k), rec_exp[k], out_pixel);
                                out_read = 1'b1;
                                k++;
                                idle = 0;
                        end else begin
                                idle++;
                                if (idle > WAIT_LIMIT) begin
                                        give_up($sformatf("result %0d", k));
                                end
                        end
                end
                next_slot();
                out_read = 1'b0;
        endtask

        task automatic wait_done();
                logic [31:0] state;
                int          idle;
                idle  = 0;
                state = '0;
                while (!state[1] && !aborted) begin
                        read_reg(REG_STATE, state);
                        idle++;
                        if (idle > WAIT_LIMIT) begin
                                give_up("the done flag");
                        end
                end
                if (!aborted) begin
                        check_word("state after run", 32'h0000_0002, state);
                        check_word("out empty after run", 32'h1, {31'd0, out_empty});
                end
        endtask

        // remaining count frozen for a few reads means the blender stopped
        task automatic wait_stall();
                logic [31:0] state;
                logic [15:0] last;
                int          same;
                int          idle;
                same  = 0;
                idle  = 0;
                last  = '1;
                state = '0;
                while (same < 4 && !aborted) begin
                        read_reg(REG_STATE, state);
                        if (state[31:16] == last) begin
                                same++;
                        end else begin
                                same = 0;
                        end
                        last = state[31:16];
                        idle++;
                        if (idle > WAIT_LIMIT) begin
                                give_up("the blender to stall");
                        end
                end
                if (!aborted && (state[31:16] == '0 || !state[0])) begin
                        errors++;
                        $display("%s: the blender finished without being held back", test_name);
                end
        endtask

        task automatic run_record();
                write_reg(REG_BLEND, {24'd0, rec_blend});
                write_reg(REG_FORMAT, 32'(rec_mode));
                if (test_name == "count_limit") begin
                        write_reg(REG_COUNT, 32'd3);
                        write_reg(REG_CONTROL, 32'd1);
                        push_pairs(0, rec_count);
                        collect_results(0, 3, 1'b0);
                        wait_done();
                        for (int i = 0; i < 10 && !aborted; i++) begin
                                next_slot();
                                check_word("out empty past count", 32'h1, {31'd0, out_empty});
                        end
                        write_reg(REG_COUNT, 32'd2);
                        write_reg(REG_CONTROL, 32'd1);
                        collect_results(3, 2, 1'b0);
                        wait_done();
                end else begin
                        write_reg(REG_COUNT, 32'(rec_count));
                        write_reg(REG_CONTROL, 32'd1);
                        push_pairs(0, rec_count);
                        if (test_name == "backpressure") begin
                                wait_stall();
                                collect_results(0, rec_count, 1'b1);
                        end else begin
                                collect_results(0, rec_count, 1'b0);
                        end
                        wait_done();
                end
        endtask

        ////////////////////////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////////////////////////

        initial begin
                int          fd;
                int          got;
                int          records;
                string       line;
                logic [31:0] value;
                logic [31:0] s;
                logic [31:0] d;
                logic [31:0] e;
                errors    = 0;
                checks    = 0;
                records   = 0;
                aborted   = 1'b0;
                seed      = 32'h6633eacc;
                arst_n    = 1'b0;
                reg_write = 1'b0;
                reg_addr  = '0;
                reg_wdata = '0;
                src_write = 1'b0;
                src_pixel = '0;
                dst_write = 1'b0;
                dst_pixel = '0;
                out_read  = 1'b0;
                repeat (4) @(posedge wire_clock);
                #10;
                arst_n = 1'b1;

                test_name = "reset";
                check_word("out empty", 32'h1, {31'd0, out_empty});
                check_word("src full", 32'h0, {31'd0, src_full});
                check_word("dst full", 32'h0, {31'd0, dst_full});
                read_reg(REG_STATE, value);
                check_word("state", 32'h0, value);
                read_reg(REG_BLEND, value);
                check_word("blend", 32'h0, value);
                read_reg(REG_COUNT, value);
                check_word("count", 32'h0, value);

                test_name = "registers";
                write_reg(REG_BLEND, 32'h0000_005c);
                read_reg(REG_BLEND, value);
                check_word("blend", 32'h0000_005c, value);
                write_reg(REG_FORMAT, 32'h0000_0001);
                read_reg(REG_FORMAT, value);
                check_word("format", 32'h0000_0001, value);
                write_reg(REG_COUNT, 32'h0000_1234);
                read_reg(REG_COUNT, value);
                check_word("count", 32'h0000_1234, value);
                read_reg(REG_CONTROL, value);
                check_word("control", 32'h0, value);
                // start with no pixels leaves the run busy
                write_reg(REG_COUNT, 32'd3);
                write_reg(REG_CONTROL, 32'd1);
                read_reg(REG_STATE, value);
                check_word("state after start", 32'h0003_0001, value);

                fd = $fopen("sim/blend_stim.txt", "r");
                if (fd == 0) begin
                        errors++;
                        $display("could not open sim/blend_stim.txt");
                end else begin
                        while (!aborted && $fscanf(fd, "%s", test_name) == 1) begin
                                if (test_name.substr(0, 1) == "//") begin
                                        got = $fgets(line, fd);
                                end else begin
                                        got = $fscanf(fd, "%d %h %d", rec_mode, rec_blend,
                                                      rec_count);
                                        if (got != 3 || rec_count > MAX_PIX) begin
                                                errors++;
                                                aborted = 1'b1;
                                                $display("bad record header in %s", test_name);
                                        end
                                        for (int i = 0; i < rec_count && !aborted; i++) begin
                                                got = $fscanf(fd, "%h %h %h", s, d, e);
                                                if (got != 3) begin
                                                        errors++;
                                                        aborted = 1'b1;
                                                        $display("short pixel list in %s",
                                                                 test_name);
                                                end
                                                rec_src[i] = s;
                                                rec_dst[i] = d;
                                                rec_exp[i] = e;
                                        end
                                        if (!aborted) begin
                                                records++;
                                                run_record();
                                        end
                                end
                        end
                        $fclose(fd);
                        if (records == 0) begin
                                errors++;
                                $display("the stimulus file held no records");
                        end
                end

                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

/* sim/blend_stim.txt */
// record: name argb_mode blend_hex count, then count triples
// triple: source_pixel destination_pixel expected_pixel, all argb hex
const_a0 0 00 2
ffffffff 12345678 12345678
aabbccdd 00102030 00102030
const_a128 0 80 2
ff204060 aa6080a0 aa406080
00ff0101 33000100 337f0100
const_a255 0 ff 2
00ff8001 77000000 77fe7f00
11000000 22ffffff 22000000
argb 1 33 4
ff102030 80ffffff 80102030
00ffffff 40123456 40123456
80ff0080 c0000080 c07f0080
40c08000 01004080 01305060
count_limit 0 80 5
00202020 a1020406 a1111213
00404040 a2020406 a2212223
00606060 a3020406 a3313233
00808080 a4020406 a4414243
00a0a0a0 a5020406 a5515253
backpressure 0 80 20
ff020202 5a402000 5a211101 ff040404 5a402000 5a221202 ff060606 5a402000 5a231303
ff080808 5a402000 5a241404 ff0a0a0a 5a402000 5a251505 ff0c0c0c 5a402000 5a261606
ff0e0e0e 5a402000 5a271707 ff101010 5a402000 5a281808 ff121212 5a402000 5a291909
ff141414 5a402000 5a2a1a0a ff161616 5a402000 5a2b1b0b ff181818 5a402000 5a2c1c0c
ff1a1a1a 5a402000 5a2d1d0d ff1c1c1c 5a402000 5a2e1e0e ff1e1e1e 5a402000 5a2f1f0f
ff202020 5a402000 5a302010 ff222222 5a402000 5a312111 ff242424 5a402000 5a322212
ff262626 5a402000 5a332313 ff282828 5a402000 5a342414

/* sim.f */
verilog/blend_pkg.sv
verilog/pixel_fifo.sv
verilog/reg_decode.sv
verilog/alpha_blender.sv
verilog/blend_render_top.sv
sim/blend_render_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= blend_render_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
